/* femtoCore_params.svh */
//************************************************************
// Build-time constants of the RV32I sequencer core
// Address width must stay between 3 and 32 bits
// Reset address is taken modulo the internal address width
//************************************************************
`ifndef FEMTO_CORE_PARAMS_SVH
`define FEMTO_CORE_PARAMS_SVH
`default_nettype none

`define FEMTO_RESET_ADDR 32'h0000_0000   // First fetch
`define FEMTO_ADDR_WIDTH 24              // PC and address adders
`define FEMTO_NUM_REGS   32              // RV32I integer registers

`default_nettype wire
`endif

/* rvIsaPkg.sv */
//************************************************************
// RV32I instruction views and decoded-instruction types
// Bits [1:0] of the opcode are expected to be 2'b11
//************************************************************
`default_nettype none

package rvIsaPkg;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rType_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iType_t;

   typedef struct packed {
      logic [6:0] immHi;   // imm[11:5]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;   // imm[4:0]
      logic [6:0] opcode;
   } sType_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
   } bType_t;

   typedef struct packed {
      logic [19:0] imm;    // imm[31:12]
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uType_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jType_t;

   // One word, six readings
   typedef union packed {
      rType_t rType;
      iType_t iType;
      sType_t sType;
      bType_t bType;
      uType_t uType;
      jType_t jType;
   } instrWord_t;

   // Exactly one flag set for a legal opcode, none otherwise
   typedef struct packed {
      logic load;
      logic aluImm;
      logic auipc;
      logic store;
      logic aluReg;
      logic lui;
      logic branch;
      logic jalr;
      logic jal;
      logic system;
   } opClass_t;

   typedef struct packed {
      opClass_t    opClass;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic        altOp;   // SUB or SRA/SRAI
      logic [31:0] imm;     // Already chosen by class
   } decoded_t;

endpackage

`default_nettype wire

/* memBusPkg.sv */
//************************************************************
// Shared memory port of the core, one port for code and data
// rstrb and nonzero wmask are single-cycle pulses
//************************************************************
`default_nettype none

package memBusPkg;

   typedef struct packed {
      logic [31:0] addr;    // Byte address, word aligned on fetch
      logic [31:0] wdata;   // Lane-replicated store data
      logic [3:0]  wmask;   // One bit per byte lane
      logic        rstrb;   // Read request
   } memReq_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        rbusy;   // Read still pending
      logic        wbusy;   // Write still pending
   } memRsp_t;

endpackage

`default_nettype wire

/* instrDecoder.sv */
//************************************************************
// Combinational RV32I decode of the latched instruction
// Unknown opcodes give an all-zero class, so nothing happens
//************************************************************
`default_nettype none

module instrDecoder (
   input  rvIsaPkg::instrWord_t instr,
   output rvIsaPkg::decoded_t   dec
);

   rvIsaPkg::opClass_t opClass;
   logic [31:0] immI, immS, immB, immU, immJ;

   // The five immediate formats
   assign immI = {{20{instr.iType.imm[11]}}, instr.iType.imm};
   assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
   assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                  instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
   assign immU = {instr.uType.imm, 12'b0};
   assign immJ = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                  instr.jType.imm11, instr.jType.imm10to1, 1'b0};

   always_comb begin
      opClass = '0;
      case (instr.rType.opcode)
         7'b0000011: opClass.load   = 1'b1;   // rd <- mem[rs1+I]
         7'b0010011: opClass.aluImm = 1'b1;   // rd <- rs1 op I
         7'b0010111: opClass.auipc  = 1'b1;   // rd <- PC+U
         7'b0100011: opClass.store  = 1'b1;   // mem[rs1+S] <- rs2
         7'b0110011: opClass.aluReg = 1'b1;   // rd <- rs1 op rs2
         7'b0110111: opClass.lui    = 1'b1;   // rd <- U
         7'b1100011: opClass.branch = 1'b1;   // PC <- PC+B if taken
         7'b1100111: opClass.jalr   = 1'b1;   // PC <- rs1+I
         7'b1101111: opClass.jal    = 1'b1;   // PC <- PC+J
         7'b1110011: opClass.system = 1'b1;   // Executes as a no-op
         default:    ;
      endcase
   end

   always_comb begin
      dec         = '0;
      dec.opClass = opClass;
      dec.funct3  = instr.rType.funct3;
      dec.rd      = instr.rType.rd;
      // funct7[5] means SUB only for register ops, SRA for both forms
      dec.altOp   = instr.rType.funct7[5] &
                    ((opClass.aluReg & (instr.rType.funct3 == 3'b000)) |
                     ((opClass.aluReg | opClass.aluImm) & (instr.rType.funct3 == 3'b101)));
      if (opClass.store)                    dec.imm = immS;
      else if (opClass.branch)              dec.imm = immB;
      else if (opClass.lui | opClass.auipc) dec.imm = immU;
      else if (opClass.jal)                 dec.imm = immJ;
      else                                  dec.imm = immI;   // Loads, ALU imm, JALR
   end

endmodule

`default_nettype wire

/* regFile.sv */
//************************************************************
// Integer register file, registered read, write at clock edge
// Read ports hold their value until the next readEn
//************************************************************
`include "femtoCore_params.svh"
`default_nettype none

module regFile (
   input  logic        clk,
   input  logic [4:0]  rs1Id,
   input  logic [4:0]  rs2Id,
   input  logic        readEn,
   input  logic [4:0]  rdId,
   input  logic        writeEn,
   input  logic [31:0] writeData,
   output logic [31:0] rs1,
   output logic [31:0] rs2
);

   logic [31:0] regs [`FEMTO_NUM_REGS];

   always_ff @(posedge clk) begin
      if (writeEn && (rdId != 5'd0))   // x0 is never written
         regs[rdId] <= writeData;
      if (readEn) begin
         rs1 <= (rs1Id == 5'd0) ? 32'd0 : regs[rs1Id];   // x0 reads zero
         rs2 <= (rs2Id == 5'd0) ? 32'd0 : regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

/* aluUnit.sv */
//************************************************************
// RV32I ALU, purely combinational
// Also gives the raw sum for JALR and the branch predicate
//************************************************************
`default_nettype none

module aluUnit (
   input  rvIsaPkg::decoded_t dec,
   input  logic [31:0]        rs1,
   input  logic [31:0]        rs2,
   output logic [31:0]        aluOut,
   output logic [31:0]        aluSum,
   output logic               predicate
);

   logic [31:0] in2;
   logic [32:0] minus;
   logic        lt, ltu, eq;
   logic [31:0] shiftIn, shiftRev;
   logic [32:0] shifted;

   // Register ops and branches compare rs2, the rest use the immediate
   assign in2 = (dec.opClass.aluReg | dec.opClass.branch) ? rs2 : dec.imm;

   assign aluSum = rs1 + in2;

   // One 33-bit subtract serves SUB and all compares
   assign minus = {1'b1, ~in2} + {1'b0, rs1} + 33'd1;
   assign ltu   = minus[32];                                 // Borrow out
   assign lt    = (rs1[31] ^ in2[31]) ? rs1[31] : minus[32];  // Signs differ
   assign eq    = (minus[31:0] == 32'd0);

   // Left shift is a right shift of the reversed word
   assign shiftIn  = (dec.funct3 == 3'b001) ? {<<{rs1}} : rs1;
   assign shifted  = $signed({dec.altOp & rs1[31], shiftIn}) >>> in2[4:0];
   assign shiftRev = {<<{shifted[31:0]}};

   always_comb begin
      case (dec.funct3)
         3'b000:  aluOut = dec.altOp ? minus[31:0] : aluSum;   // ADD/SUB
         3'b001:  aluOut = shiftRev;                           // SLL
         3'b010:  aluOut = {31'd0, lt};                        // SLT
         3'b011:  aluOut = {31'd0, ltu};                       // SLTU
         3'b100:  aluOut = rs1 ^ in2;
         3'b101:  aluOut = shifted[31:0];                      // SRL/SRA
         3'b110:  aluOut = rs1 | in2;
         default: aluOut = rs1 & in2;
      endcase
   end

   always_comb begin
      case (dec.funct3)
         3'b000:  predicate = eq;     // BEQ
         3'b001:  predicate = ~eq;    // BNE
         3'b100:  predicate = lt;     // BLT
         3'b101:  predicate = ~lt;    // BGE
         3'b110:  predicate = ltu;    // BLTU
         3'b111:  predicate = ~ltu;   // BGEU
         default: predicate = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* loadStoreUnit.sv */
//************************************************************
// Load/store datapath of the core, purely combinational
// Misaligned halfword and word accesses are not trapped
// storeMask is raw, the top gates it with the execute state
//************************************************************
`include "femtoCore_params.svh"
`default_nettype none

module loadStoreUnit (
   input  rvIsaPkg::decoded_t             dec,
   input  logic [31:0]                    rs1,
   input  logic [31:0]                    rs2,
   input  logic [31:0]                    rdata,
   output logic [`FEMTO_ADDR_WIDTH-1:0]   addr,
   output logic [31:0]                    wdata,
   output logic [3:0]                     storeMask,
   output logic [31:0]                    loadData
);

   logic        byteAccess, halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // Immediate is already S for stores and I for loads
   assign addr = rs1[`FEMTO_ADDR_WIDTH-1:0] + dec.imm[`FEMTO_ADDR_WIDTH-1:0];

   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   // Byte replicated on all lanes, halfword on both halves
   assign wdata[7:0]   = rs2[7:0];
   assign wdata[15:8]  = addr[0] ? rs2[7:0] : rs2[15:8];
   assign wdata[23:16] = addr[1] ? rs2[7:0] : rs2[23:16];
   assign wdata[31:24] = addr[0] ? rs2[7:0] : (addr[1] ? rs2[15:8] : rs2[31:24]);

   always_comb begin
      if (byteAccess)
         storeMask = 4'b0001 << addr[1:0];        // One lane
      else if (halfAccess)
         storeMask = addr[1] ? 4'b1100 : 4'b0011;  // Upper or lower pair
      else
         storeMask = 4'b1111;
   end

   // Pick the addressed halfword, then the byte inside it
   assign loadHalf = addr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);   // LBU/LHU

   always_comb begin
      if (byteAccess)
         loadData = {{24{loadSign}}, loadByte};
      else if (halfAccess)
         loadData = {{16{loadSign}}, loadHalf};
      else
         loadData = rdata;
   end

endmodule

`default_nettype wire

/* femtoCore.sv */
//************************************************************
// Multicycle RV32I core on one shared memory port
// One instruction in flight, no interrupts, no CSRs
// PC steps by 4, upper address bits above the width are zero
// Loads write back again once memory drops rbusy
//************************************************************
`include "femtoCore_params.svh"
`default_nettype none

module femtoCore (
   input  logic                clk,
   input  logic                reset,
   output memBusPkg::memReq_t  memReq,
   input  memBusPkg::memRsp_t  memRsp
);

   localparam int AW = `FEMTO_ADDR_WIDTH;

   // One-hot state bits
   localparam int FETCH_BIT      = 0;
   localparam int WAIT_INSTR_BIT = 1;
   localparam int EXECUTE_BIT    = 2;
   localparam int WAIT_MEM_BIT   = 3;
   localparam logic [3:0] FETCH      = 4'b0001 << FETCH_BIT;
   localparam logic [3:0] WAIT_INSTR = 4'b0001 << WAIT_INSTR_BIT;
   localparam logic [3:0] EXECUTE    = 4'b0001 << EXECUTE_BIT;
   localparam logic [3:0] WAIT_MEM   = 4'b0001 << WAIT_MEM_BIT;

   logic [3:0]           state;
   logic [AW-1:0]        pc;
   logic                 loadPending;   // Load result still to arrive
   rvIsaPkg::instrWord_t instr;         // Latched instruction
   rvIsaPkg::instrWord_t fetched;       // Word on the bus right now
   rvIsaPkg::decoded_t   dec;
   logic [31:0]          rs1, rs2, aluOut, aluSum, lsWdata, loadData, wbData;
   logic [AW-1:0]        lsAddr, pcPlus4, pcPlusImm, pcNext;
   logic [3:0]           storeMask;
   logic                 predicate, writesRd, writeEn, readEn, needWait;

   assign fetched = memRsp.rdata;

   instrDecoder decoder (.instr(instr), .dec(dec));

   regFile regs (
      .clk(clk), .rs1Id(fetched.rType.rs1), .rs2Id(fetched.rType.rs2),
      .readEn(readEn), .rdId(dec.rd), .writeEn(writeEn), .writeData(wbData),
      .rs1(rs1), .rs2(rs2)
   );

   aluUnit alu (
      .dec(dec), .rs1(rs1), .rs2(rs2),
      .aluOut(aluOut), .aluSum(aluSum), .predicate(predicate)
   );

   loadStoreUnit lsu (
      .dec(dec), .rs1(rs1), .rs2(rs2), .rdata(memRsp.rdata),
      .addr(lsAddr), .wdata(lsWdata), .storeMask(storeMask), .loadData(loadData)
   );

   assign pcPlus4   = pc + AW'(4);
   assign pcPlusImm = pc + dec.imm[AW-1:0];   // Branch, JAL and AUIPC target

   always_comb begin
      if (dec.opClass.jalr)
         pcNext = {aluSum[AW-1:1], 1'b0};
      else if (dec.opClass.jal | (dec.opClass.branch & predicate))
         pcNext = pcPlusImm;
      else
         pcNext = pcPlus4;
   end

   // Classes are one-hot so the terms never overlap
   assign wbData = ({32{dec.opClass.aluReg | dec.opClass.aluImm}} & aluOut)
                 | ({32{dec.opClass.lui}}                      & dec.imm)
                 | ({32{dec.opClass.auipc}}                    & 32'(pcPlusImm))
                 | ({32{dec.opClass.jal | dec.opClass.jalr}}   & 32'(pcPlus4))
                 | ({32{dec.opClass.load}}                     & loadData);

   assign writesRd = dec.opClass.aluReg | dec.opClass.aluImm | dec.opClass.lui |
                     dec.opClass.auipc | dec.opClass.jal | dec.opClass.jalr | dec.opClass.load;

   // Execute write, then the final load data when it arrives
   assign writeEn = (state[EXECUTE_BIT] & writesRd)
                  | (state[WAIT_MEM_BIT] & loadPending & ~memRsp.rbusy);

   assign readEn   = state[WAIT_INSTR_BIT] & ~memRsp.rbusy;
   assign needWait = dec.opClass.load | dec.opClass.store;

   // Memory port
   assign memReq.addr  = (state[FETCH_BIT] | state[WAIT_INSTR_BIT]) ?
                         32'({pc[AW-1:2], 2'b00}) : 32'(lsAddr);
   assign memReq.wdata = lsWdata;
   assign memReq.wmask = {4{state[EXECUTE_BIT] & dec.opClass.store}} & storeMask;
   assign memReq.rstrb = state[FETCH_BIT] | (state[EXECUTE_BIT] & dec.opClass.load);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state       <= WAIT_MEM;   // Wait for the memory to go idle
         pc          <= AW'(`FEMTO_RESET_ADDR);
         loadPending <= 1'b0;
      end else begin
         case (1'b1)
            state[FETCH_BIT]: state <= WAIT_INSTR;
            state[WAIT_INSTR_BIT]: if (!memRsp.rbusy) state <= EXECUTE;
            state[EXECUTE_BIT]: begin
               pc          <= pcNext;
               loadPending <= dec.opClass.load;
               state       <= needWait ? WAIT_MEM : FETCH;
            end
            state[WAIT_MEM_BIT]: begin
               if (!memRsp.rbusy && !memRsp.wbusy) begin
                  loadPending <= 1'b0;
                  state       <= FETCH;
               end
            end
            default: state <= WAIT_MEM;   // Recover from a broken one-hot code
         endcase
      end
   end

   // Instruction latched with the register read
   always_ff @(posedge clk) begin
      if (readEn) instr <= fetched;
   end

endmodule

`default_nettype wire

/* femtoCore_asserts.sv */
//************************************************************
// Memory port checks for the core, bound to femtoCore
// Assumes the first fetch reads the reset address
//************************************************************
`include "femtoCore_params.svh"
`default_nettype none

module femtoCoreAsserts (
   input logic               clk,
   input logic               reset,
   input memBusPkg::memReq_t memReq
);

   timeunit 1ns;
   timeprecision 100ps;

   logic fetchSeen;   // Set by the first read strobe after reset

   always_ff @(posedge clk) begin
      if (!reset)
         fetchSeen <= 1'b0;
      else if (memReq.rstrb)
         fetchSeen <= 1'b1;
   end

   // Read and write never share a cycle
   noReadWithWrite: assert property (@(posedge clk) disable iff (!reset)
      !(memReq.rstrb && (memReq.wmask != 4'b0000)))
      else $error("Read strobe and write mask active in the same cycle");

   // One lane, a lane pair or the whole word
   legalMask: assert property (@(posedge clk) disable iff (!reset)
      memReq.wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                           4'b0011, 4'b1100, 4'b1111})
      else $error("Illegal write mask %b", memReq.wmask);

   // Quiet port until the first fetch, which goes to the reset address
   quietUntilFetch: assert property (@(posedge clk) disable iff (!reset)
      !fetchSeen |-> (memReq.wmask == 4'b0000) &&
                     (!memReq.rstrb || (memReq.addr == 32'(`FEMTO_RESET_ADDR))))
      else $error("Memory port active before the first fetch");

endmodule

`default_nettype wire

/* femtoCoreTb.sv */
//************************************************************
// Testbench for the core with a stalling byte-masked memory
// Program and expected stores come from femtoCore_stim.txt
// Memory holds 4 KB and higher addresses alias onto it
//************************************************************
`include "femtoCore_params.svh"
`default_nettype none

module femtoCoreTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int STIM_WORDS = 256;
   localparam int MEM_WORDS  = 1024;
   localparam logic [31:0] RESET_ADDR = `FEMTO_RESET_ADDR;

   logic               clk;
   logic               reset;
   memBusPkg::memReq_t memReq;
   memBusPkg::memRsp_t memRsp;

   logic [31:0] stim [STIM_WORDS];
   logic [31:0] mem  [MEM_WORDS];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic [3:0]  expMask [$];
   int          progLen, numExp, storeIdx;
   int          checks, mismatches, otherErrors;
   logic        loaded;
   logic [31:0] lcgState;

   femtoCore femtoCore_inst (.clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp));

   bind femtoCore femtoCoreAsserts asserts (.clk(clk), .reset(reset), .memReq(memReq));

   function automatic logic [31:0] lcgStep(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Byte mask widened to a bit mask
   function automatic logic [31:0] laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic compareValue(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   initial begin
      reset = 1'b0;
      repeat (16) @(posedge clk);
      #1 reset = 1'b1;
   end

   // Memory model, store checker and stimulus loader
   initial begin : memoryModel
      int                 i, idx, rdCount, wrCount;
      memBusPkg::memReq_t req;
      logic               reqValid;
      memRsp      = '0;
      loaded      = 1'b0;
      lcgState    = 32'hb7fe_5571;
      storeIdx    = 0;
      checks      = 0;
      mismatches  = 0;
      otherErrors = 0;
      rdCount     = 0;
      wrCount     = 0;
      for (i = 0; i < STIM_WORDS; i++) stim[i] = 32'hFFFF_FFFF;   // Acts as end marker
      $readmemh("femtoCore_stim.txt", stim);
      for (i = 0; i < MEM_WORDS; i++)
         mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;   // Whole-address fill
      progLen = int'(stim[0]);
      for (i = 0; i < progLen; i++)
         mem[RESET_ADDR[11:2] + 10'(i)] = stim[i + 1];   // Image starts at the reset address
      idx = progLen + 1;
      while ((idx + 2 < STIM_WORDS) && (stim[idx] != 32'hFFFF_FFFF)) begin
         expAddr.push_back(stim[idx]);
         expData.push_back(stim[idx + 1]);
         expMask.push_back(stim[idx + 2][3:0]);
         idx += 3;
      end
      numExp = expAddr.size();
      loaded = 1'b1;
      forever begin
         @(negedge clk);           // Requests are stable mid-cycle
         req      = memReq;
         reqValid = reset;
         @(posedge clk);
         #1;
         if (rdCount > 0) rdCount--;
         if (wrCount > 0) wrCount--;
         if (reqValid && req.rstrb) begin
            memRsp.rdata = mem[req.addr[11:2]];
            lcgState     = lcgStep(lcgState);
            rdCount      = int'(lcgState[31:30]);   // 0 to 3 busy cycles
         end
         if (reqValid && (req.wmask != 4'b0000)) begin
            for (i = 0; i < 4; i++)
               if (req.wmask[i]) mem[req.addr[11:2]][8*i +: 8] = req.wdata[8*i +: 8];
            if (storeIdx >= numExp) begin
               otherErrors++;
               $display("Unexpected store of %h to address %h at %0t ns after the list ended",
                        req.wdata, req.addr, $time);
            end else begin
               compareValue($sformatf("store %0d address", storeIdx), req.addr,
                            expAddr[storeIdx]);
               compareValue($sformatf("store %0d mask", storeIdx), {28'd0, req.wmask},
                            {28'd0, expMask[storeIdx]});
               compareValue($sformatf("store %0d data", storeIdx),
                            req.wdata & laneBits(expMask[storeIdx]),
                            expData[storeIdx] & laneBits(expMask[storeIdx]));   // Live lanes only
               storeIdx++;
            end
            lcgState = lcgStep(lcgState);
            wrCount  = int'(lcgState[31:30]);
         end
         memRsp.rbusy = (rdCount > 0);
         memRsp.wbusy = (wrCount > 0);
      end
   end

   initial begin : mainSequence
      wait (loaded);
      wait (storeIdx == numExp);
      repeat (40) @(posedge clk);   // Catch stray stores after the last one
      $display("Checks: %0d, mismatches: %0d, other errors: %0d, stores seen: %0d of %0d",
               checks, mismatches, otherErrors, storeIdx, numExp);
      if ((mismatches == 0) && (otherErrors == 0) && (numExp > 0))
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = (progLen * 3 + numExp * 4) * 8;   // Cycles
      repeat (limit) @(posedge clk);
      $display("Timeout: program did not finish, %0d of %0d stores seen after %0d cycles",
               storeIdx, numExp, limit);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* femtoCore_stim.txt */
// Word 0: program length in words, then the program words from address 0
// Then store records: byte address, data, mask; end marker FFFFFFFF
00000053
// Setup x1=0x400, x2=-7, x3=5
40000093 FF900113 00500193
// add sub slt sltu xor or and sll srl sra, each stored to 0x400..
00310233 0040A023 40218233 0040A223
00312233 0040A423 00313233 0040A623
00314233 0040A823 00316233 0040AA23
00317233 0040AC23 00311233 0040AE23
00315233 0240A023 40315233 0240A223
// srai, lui, auipc at 0x6C, xori
40115213 0240A423 12345237 0240A623
00001217 0240A823 0F014213 0240AA23
// addi x0 then store x0
00500013 0200AC23
// x5=0x11223344, sb at offsets 0..3, sh at 0 and 2
112232B7 34428293 04508023 045080A3
04508123 045081A3 04509423 04509523
// sw FFFFFF09 to 0x450, lb lbu lh lhu each stored back
0440A823 05108303 0460AA23 0510C303
0460AC23 05009303 0460AE23 0500D303
0660A023
// Branch pairs, taken ones skip a store to 0x480
00310463 0630A423 00318463 0830A023 00311463 0830A023 00319463 0630A623
00314463 0830A023 0021C463 0630A823 0021D463 0830A023 00315463 0630AA23
0021E463 0830A023 00316463 0630AC23 00317463 0830A023 0021F463 0630AE23
// jal at 0x128, auipc and jalr at 0x134, ecall, spin
0080046F 0830A023 0880A223
00000497 00C48567 0830A023 08A0A423
00000073 0000006F
// Expected stores
00000400 FFFFFFFE F   00000404 0000000C F   00000408 00000001 F
0000040C 00000000 F   00000410 FFFFFFFC F   00000414 FFFFFFFD F
00000418 00000001 F   0000041C FFFFFF20 F   00000420 07FFFFFF F
00000424 FFFFFFFF F   00000428 FFFFFFFC F   0000042C 12345000 F
00000430 0000106C F   00000434 FFFFFF09 F   00000438 00000000 F
00000440 00000044 1   00000441 00004400 2   00000442 00440000 4
00000443 44000000 8   00000448 00003344 3   0000044A 33440000 C
00000450 FFFFFF09 F   00000454 FFFFFFFF F   00000458 000000FF F
0000045C FFFFFF09 F   00000460 0000FF09 F
00000468 00000005 F   0000046C 00000005 F   00000470 00000005 F
00000474 00000005 F   00000478 00000005 F   0000047C 00000005 F
00000484 0000012C F   00000488 0000013C F
FFFFFFFF

/* compile.f */
+incdir+.
rvIsaPkg.sv
memBusPkg.sv
instrDecoder.sv
regFile.sv
aluUnit.sv
loadStoreUnit.sv
femtoCore.sv
femtoCore_asserts.sv
femtoCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := femtoCoreTb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
